/* all.f */
+incdir+.
opn_pkg.sv
opn_wr_if.sv
opn_cpu_port.sv
opn_wr_queue.sv
opn_timers.sv
opn_top.sv
opn_tb.sv

/* Bender.yml */
package:
  name: opn_timer_port

sources:
  - files:
      - opn_pkg.sv
      - opn_wr_if.sv
      - opn_cpu_port.sv
      - opn_wr_queue.sv
      - opn_timers.sv
      - opn_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - opn_tb.sv

/* opn_tb_ref.svh */
// Reference model functions for the timer testbench
// Include inside the testbench module after the package is compiled
`ifndef OPN_TB_REF_SVH
`define OPN_TB_REF_SVH

// Clocks between two timer A overflows
function automatic int unsigned ref_period_a(input int unsigned value_a);
    return ((1 << opn_pkg::TA_W) - value_a) * opn_pkg::TICK_DIV;
endfunction

// Clocks between two timer B overflows, prescaler included
function automatic int unsigned ref_period_b(input int unsigned value_b);
    return ((1 << opn_pkg::TB_W) - value_b) * opn_pkg::TB_PRESCALE * opn_pkg::TICK_DIV;
endfunction

// Expected status byte on dout
function automatic logic [opn_pkg::DATA_W-1:0] ref_status(
    input logic busy,
    input logic flag_b,
    input logic flag_a
);
    logic [opn_pkg::DATA_W-1:0] s;
    s                         = '0;
    s[opn_pkg::STATUS_BUSY]   = busy;
    s[opn_pkg::STATUS_FLAG_B] = flag_b;
    s[opn_pkg::STATUS_FLAG_A] = flag_a;
    return s;
endfunction

`endif

/* opn_tb.sv */
// Testbench for the FM chip CPU port, write queue and timers
// Covers reset state, timer periods, flag enables, busy back-pressure and part 1 writes
`timescale 1ns/10ps

module opn_tb;
    import opn_pkg::*;

    localparam int CLK_NS = 10;

    logic              clk = 1'b0;
    logic              rst_n;
    logic [DATA_W-1:0] din;
    logic [1:0]        addr;
    logic              cs_n;
    logic              wr_n;
    logic [DATA_W-1:0] dout;
    logic              irq_n;

    int unsigned errors = 0;
    int unsigned checks_sent = 0;
    int unsigned checks_done = 0;
    int unsigned tests_run = 0;
    int unsigned wd_cycles = 0;
    logic        busy_seen = 1'b0;
    logic        busy_fell = 1'b0;
    logic        busy_last = 1'b0;
    string       name_q[$];
    longint      exp_q[$];
    longint      act_q[$];

    `include "opn_tb_ref.svh"

    opn_top UUT (
        .clk   ( clk   ),
        .rst_n ( rst_n ),
        .din   ( din   ),
        .addr  ( addr  ),
        .cs_n  ( cs_n  ),
        .wr_n  ( wr_n  ),
        .dout  ( dout  ),
        .irq_n ( irq_n )
    );

    always #(CLK_NS / 2) clk = ~clk;

    // Control byte, fields sit in bits 0 to 5
    function automatic logic [DATA_W-1:0] ctl_byte(input logic load_a, load_b, en_a, en_b,
                                                   input logic rst_a, rst_b);
        return DATA_W'({rst_b, rst_a, en_b, en_a, load_b, load_a});
    endfunction

    task automatic submit_check(input string name, input longint expected, input longint actual);
        name_q.push_back(name);
        exp_q.push_back(expected);
        act_q.push_back(actual);
        checks_sent++;
    endtask

    task automatic note_busy(input logic busy);
        if (busy) busy_seen = 1'b1;
        if (busy_last && !busy) busy_fell = 1'b1;  // Queue just lost its full state
        busy_last = busy;
    endtask

    // One bus cycle with a low strobe and one idle cycle, busy sampled on each negedge
    task automatic bus_write(input logic [1:0] a, input logic [DATA_W-1:0] d);
        @(posedge clk);
        addr <= a;
        din  <= d;
        cs_n <= 1'b0;
        wr_n <= 1'b0;
        @(negedge clk);
        note_busy(dout[STATUS_BUSY]);
        @(posedge clk);
        cs_n <= 1'b1;
        wr_n <= 1'b1;
        @(negedge clk);
        note_busy(dout[STATUS_BUSY]);
    endtask

    task automatic wait_not_busy();
        @(negedge clk);
        while (dout[STATUS_BUSY]) @(negedge clk);
    endtask

    task automatic write_reg(input logic part, input logic [REG_ADDR_W-1:0] ra,
                             input logic [DATA_W-1:0] d);
        wait_not_busy();
        bus_write({part, 1'b0}, ra);
        wait_not_busy();
        bus_write({part, 1'b1}, d);
    endtask

    task automatic wait_rise(input int idx, output longint t);
        logic prev;
        prev = dout[idx];
        @(negedge clk);
        while (!(dout[idx] && !prev)) begin
            prev = dout[idx];
            @(negedge clk);
        end
        t = $time;
    endtask

    // Clocks between two flag rises, flag cleared in between
    task automatic measure_period(input int idx, input logic [DATA_W-1:0] clear_ctl,
                                  output longint cycles);
        longint t1;
        longint t2;
        wait_rise(idx, t1);
        write_reg(1'b0, REG_TIMER_CTL, clear_ctl);
        wait_rise(idx, t2);
        cycles = (t2 - t1) / CLK_NS;
    endtask

    task automatic finish_test(input string name, input int unsigned errs_before);
        wait (checks_done == checks_sent);
        tests_run++;
        if (errors == errs_before)
            $display("%s: PASS", name);
        else
            $display("%s: FAIL", name);
    endtask

    // Compare process
    initial begin
        forever begin
            wait (name_q.size() != 0);
            if (act_q[0] != exp_q[0]) begin
                $display("ERR %s: expected %0d, actual %0d", name_q[0], exp_q[0], act_q[0]);
                errors++;
            end
            void'(name_q.pop_front());
            void'(exp_q.pop_front());
            void'(act_q.pop_front());
            checks_done++;
        end
    end

    initial begin
        wait (wd_cycles != 0);
        repeat (wd_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not finish", wd_cycles);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        int unsigned v1;
        int unsigned v2;
        int unsigned vb;
        int unsigned pa;
        int unsigned pb;
        int unsigned e0;
        int unsigned cnt;
        int          i;
        longint      t;
        rst_n = 1'b0;
        cs_n  = 1'b1;
        wr_n  = 1'b1;
        addr  = '0;
        din   = '0;
        void'($urandom(32'h7389_b8df));
        v1 = $urandom % 1000;   // Keeps timer A period long enough to clear the flag
        v2 = v1 ^ 32'h200;
        vb = 200 + $urandom % 50;
        pa = ref_period_a(v1);
        pb = ref_period_b(vb);
        wd_cycles = 2 * (8 * pa + 3 * pb) + 4000;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);

        e0 = errors;
        submit_check("reset_dout", ref_status(0, 0, 0), dout);
        submit_check("reset_irq_n", 1, irq_n);
        finish_test("reset_state", e0);

        e0 = errors;
        write_reg(0, REG_TA_HI, v1[TA_W-1:TA_W-DATA_W]);
        write_reg(0, REG_TA_LO, v1[TA_W-DATA_W-1:0]);
        write_reg(0, REG_TIMER_CTL, ctl_byte(1, 0, 1, 0, 1, 1));
        measure_period(STATUS_FLAG_A, ctl_byte(1, 0, 1, 0, 1, 0), t);
        submit_check("timer_a_period", pa, t);
        write_reg(0, REG_TIMER_CTL, '0);
        finish_test("timer_a", e0);

        e0 = errors;
        write_reg(0, REG_TB, vb[TB_W-1:0]);
        write_reg(0, REG_TIMER_CTL, ctl_byte(0, 1, 0, 1, 1, 1));
        measure_period(STATUS_FLAG_B, ctl_byte(0, 1, 0, 1, 0, 1), t);
        submit_check("timer_b_period", pb, t);
        submit_check("timer_b_status", ref_status(0, 1, 0), dout);
        submit_check("timer_b_irq_n", 0, irq_n);
        write_reg(0, REG_TIMER_CTL, ctl_byte(0, 1, 0, 1, 0, 1));
        while (dout[STATUS_FLAG_B]) @(negedge clk);
        submit_check("timer_b_irq_clear", 1, irq_n);
        write_reg(0, REG_TIMER_CTL, '0);
        finish_test("timer_b", e0);

        e0 = errors;
        write_reg(0, REG_TIMER_CTL, ctl_byte(1, 0, 0, 0, 1, 1));
        while (dout != '0) @(negedge clk);
        cnt = 0;
        repeat (pa + 2 * TICK_DIV) begin
            @(negedge clk);
            if (dout[STATUS_FLAG_A] || !irq_n) cnt++;
        end
        submit_check("disabled_flag_cycles", 0, cnt);
        finish_test("timer_disabled", e0);

        // Saturate the queue with the current value, then slip in a new one while full
        e0 = errors;
        wait_not_busy();
        bus_write(2'b00, REG_TA_HI);
        busy_seen = 1'b0;
        busy_fell = 1'b0;
        busy_last = 1'b0;
        i = 0;
        while (!busy_fell && i < 16) begin
            bus_write(2'b01, v1[TA_W-1:TA_W-DATA_W]);
            i++;
        end
        bus_write(2'b01, v2[TA_W-1:TA_W-DATA_W]);  // Refill came just before, queue full
        submit_check("burst_busy_seen", 1, busy_seen);
        submit_check("burst_busy_cleared", 1, busy_fell);
        write_reg(0, REG_TIMER_CTL, ctl_byte(1, 0, 1, 0, 1, 1));
        measure_period(STATUS_FLAG_A, ctl_byte(1, 0, 1, 0, 1, 0), t);
        submit_check("burst_timer_a_period", pa, t);
        write_reg(0, REG_TIMER_CTL, '0);
        finish_test("busy_drop", e0);

        e0 = errors;
        write_reg(1, REG_TA_HI, v2[TA_W-1:TA_W-DATA_W]);
        write_reg(1, REG_TA_LO, v2[TA_W-DATA_W-1:0]);
        write_reg(1, REG_TIMER_CTL, ctl_byte(1, 1, 1, 1, 0, 0));
        write_reg(0, REG_TIMER_CTL, ctl_byte(1, 0, 1, 0, 1, 1));
        measure_period(STATUS_FLAG_A, ctl_byte(1, 0, 1, 0, 1, 0), t);
        submit_check("part1_timer_a_period", pa, t);
        finish_test("part1_ignored", e0);

        $display("%0d tests, %0d checks, %0d errors", tests_run, checks_done, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

/* opn_top.sv */
// Top level of the FM chip CPU interface with timers and irq
// Bus writes flow from the port through the write queue into the timer block
`timescale 1ns/10ps

module opn_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [opn_pkg::DATA_W-1:0] din,
    input  logic [1:0]                 addr,
    input  logic                       cs_n,
    input  logic                       wr_n,
    output logic [opn_pkg::DATA_W-1:0] dout,
    output logic                       irq_n
);

    logic flag_a;
    logic flag_b;

    opn_wr_if cpu_wr ();    // Port to queue
    opn_wr_if reg_wr ();    // Queue to timers

    opn_cpu_port u_port (
        .clk    ( clk    ),
        .rst_n  ( rst_n  ),
        .din    ( din    ),
        .addr   ( addr   ),
        .cs_n   ( cs_n   ),
        .wr_n   ( wr_n   ),
        .flag_a ( flag_a ),
        .flag_b ( flag_b ),
        .dout   ( dout   ),
        .wr     ( cpu_wr )
    );

    opn_wr_queue u_queue (
        .clk    ( clk    ),
        .rst_n  ( rst_n  ),
        .wr_in  ( cpu_wr ),
        .wr_out ( reg_wr )
    );

    opn_timers u_timers (
        .clk    ( clk    ),
        .rst_n  ( rst_n  ),
        .wr     ( reg_wr ),
        .flag_a ( flag_a ),
        .flag_b ( flag_b ),
        .irq_n  ( irq_n  )
    );

endmodule

/* opn_timers.sv */
// Timer register block: accepts one queued write per tick and runs timers A and B
// Flags are set on overflow when enabled and cleared through the control register
`timescale 1ns/10ps

module opn_timers (
    input  logic  clk,
    input  logic  rst_n,
    opn_wr_if.dst wr,
    output logic  flag_a,
    output logic  flag_b,
    output logic  irq_n
);
    import opn_pkg::*;

    logic [TICK_CNT_W-1:0] div_cnt;
    logic                  tick;
    logic                  apply;
    logic                  ctl_wr;
    logic [TA_W-1:0]       value_a;
    logic [TB_W-1:0]       value_b;
    logic                  load_a;
    logic                  load_b;
    logic                  en_a;
    logic                  en_b;
    logic [TA_W-1:0]       cnt_a;
    logic [TB_W-1:0]       cnt_b;
    logic [TB_PRE_W-1:0]   pre_b;
    logic                  start_a;
    logic                  start_b;
    logic                  ovf_a;
    logic                  step_b;
    logic                  ovf_b;

    assign tick     = div_cnt == TICK_CNT_W'(TICK_DIV - 1);
    assign wr.ready = tick;     // One write per tick
    assign apply    = wr.valid && tick && !wr.part;
    assign ctl_wr   = apply && wr.reg_addr == REG_TIMER_CTL;

    // Counters restart only on a 0 to 1 change of the load bit
    assign start_a = ctl_wr && wr.reg_data[CTL_LOAD_A] && !load_a;
    assign start_b = ctl_wr && wr.reg_data[CTL_LOAD_B] && !load_b;

    assign ovf_a  = tick && load_a && cnt_a == '1;
    assign step_b = tick && load_b && pre_b == TB_PRE_W'(TB_PRESCALE - 1);
    assign ovf_b  = step_b && cnt_b == '1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= tick ? '0 : div_cnt + 1'b1;
        end
    end

    // Register decode
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            value_a <= '0;
            value_b <= '0;
            load_a  <= 1'b0;
            load_b  <= 1'b0;
            en_a    <= 1'b0;
            en_b    <= 1'b0;
        end else if (apply) begin
            case (wr.reg_addr)
                REG_TA_HI: value_a[TA_W-1:TA_W-DATA_W] <= wr.reg_data;
                REG_TA_LO: value_a[TA_W-DATA_W-1:0] <= wr.reg_data[TA_W-DATA_W-1:0];
                REG_TB:    value_b <= wr.reg_data;
                REG_TIMER_CTL: begin
                    load_a <= wr.reg_data[CTL_LOAD_A];
                    load_b <= wr.reg_data[CTL_LOAD_B];
                    en_a   <= wr.reg_data[CTL_EN_A];
                    en_b   <= wr.reg_data[CTL_EN_B];
                end
                default: ;  // Not a timer register
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_a <= '0;
            cnt_b <= '0;
            pre_b <= '0;
        end else begin
            if (start_a) begin
                cnt_a <= value_a;
            end else if (tick && load_a) begin
                cnt_a <= ovf_a ? value_a : cnt_a + 1'b1;  // Reload on overflow tick
            end

            if (start_b) begin
                cnt_b <= value_b;
                pre_b <= '0;
            end else if (tick && load_b) begin
                pre_b <= pre_b + 1'b1;  // Wraps after TB_PRESCALE ticks
                if (step_b) begin
                    cnt_b <= ovf_b ? value_b : cnt_b + 1'b1;
                end
            end
        end
    end

    // Overflow wins over a clear in the same tick
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flag_a <= 1'b0;
            flag_b <= 1'b0;
            irq_n  <= 1'b1;
        end else begin
            if (ovf_a && en_a) begin
                flag_a <= 1'b1;
            end else if (ctl_wr && wr.reg_data[CTL_RST_A]) begin
                flag_a <= 1'b0;
            end
            if (ovf_b && en_b) begin
                flag_b <= 1'b1;
            end else if (ctl_wr && wr.reg_data[CTL_RST_B]) begin
                flag_b <= 1'b0;
            end
            irq_n <= !(flag_a || flag_b);
        end
    end

    a_irq_follows_flags: assert property (
        @(posedge clk) disable iff (!rst_n)
        irq_n == !($past(flag_a) || $past(flag_b))
    );

endmodule

/* opn_wr_queue.sv */
// Small FIFO of register writes between the CPU port and the timer block
// Ready upstream drops while full, which shows as busy on the status byte
`timescale 1ns/10ps

module opn_wr_queue (
    input  logic  clk,
    input  logic  rst_n,
    opn_wr_if.dst wr_in,
    opn_wr_if.src wr_out
);
    import opn_pkg::*;

    reg_write_t             mem [QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0] rd_ptr;
    logic [QUEUE_PTR_W-1:0] wr_ptr;
    logic [QUEUE_CNT_W-1:0] count;
    logic                   push;
    logic                   pop;
    reg_write_t             head;

    assign push = wr_in.valid && wr_in.ready;
    assign pop  = wr_out.valid && wr_out.ready;

    assign wr_in.ready  = count != QUEUE_CNT_W'(QUEUE_DEPTH);
    assign wr_out.valid = count != '0;

    // Head entry drives the downstream payload
    assign head            = mem[rd_ptr];
    assign wr_out.part     = head.part;
    assign wr_out.reg_addr = head.reg_addr;
    assign wr_out.reg_data = head.reg_data;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_in.word;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;    // Wraps at depth
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_count_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        count <= QUEUE_CNT_W'(QUEUE_DEPTH)
    );

    // The port must hold back a write once it has seen the queue full
    a_no_push_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr_in.valid |-> count < QUEUE_CNT_W'(QUEUE_DEPTH)
    );

endmodule

/* opn_cpu_port.sv */
// CPU side of the chip: address latch per part, data write strobe and status read
// A data write is only pushed when the queue reports space, else it is lost
`timescale 1ns/10ps

module opn_cpu_port (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [opn_pkg::DATA_W-1:0] din,
    input  logic [1:0]                 addr,
    input  logic                       cs_n,
    input  logic                       wr_n,
    input  logic                       flag_a,
    input  logic                       flag_b,
    output logic [opn_pkg::DATA_W-1:0] dout,
    opn_wr_if.src                      wr
);
    import opn_pkg::*;

    logic                  bus_wr;
    logic                  bus_wr_q;
    logic                  wr_edge;
    logic                  data_wr;
    logic [REG_ADDR_W-1:0] addr_lat [2];    // One latched address per part
    logic [DATA_W-1:0]     status;

    assign bus_wr  = !cs_n && !wr_n;
    assign wr_edge = bus_wr && !bus_wr_q;   // Act once per write cycle
    assign data_wr = wr_edge && addr[0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bus_wr_q <= 1'b0;
            wr.valid <= 1'b0;
            addr_lat <= '{default: '0};
        end else begin
            bus_wr_q <= bus_wr;
            wr.valid <= data_wr && wr.ready;    // Dropped while busy
            if (wr_edge && !addr[0]) begin
                addr_lat[addr[1]] <= din;
            end
        end
    end

    // Payload follows the strobe
    always_ff @(posedge clk) begin
        if (data_wr) begin
            wr.part     <= addr[1];
            wr.reg_addr <= addr_lat[addr[1]];
            wr.reg_data <= din;
        end
    end

    always_comb begin
        status                = '0;
        status[STATUS_BUSY]   = !wr.ready;  // Queue full
        status[STATUS_FLAG_B] = flag_b;
        status[STATUS_FLAG_A] = flag_a;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dout <= '0;
        end else begin
            dout <= status;
        end
    end

    // Bus edges are at least two cycles apart, so pushes never merge
    a_valid_strobe: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr.valid |=> !wr.valid
    );

endmodule

/* opn_wr_if.sv */
// One register write moving between internal blocks
// Valid is a single-cycle strobe, ready is a level owned by the receiver
`timescale 1ns/10ps

interface opn_wr_if;
    import opn_pkg::*;

    logic                  valid;
    logic                  ready;
    logic                  part;
    logic [REG_ADDR_W-1:0] reg_addr;
    logic [DATA_W-1:0]     reg_data;
    reg_write_t            word;    // Packed view for storage

    assign word = '{part: part, reg_addr: reg_addr, reg_data: reg_data};

    modport src (
        output valid, part, reg_addr, reg_data,
        input  ready
    );

    modport dst (
        input  valid, part, reg_addr, reg_data, word,
        output ready
    );

endinterface

/* opn_pkg.sv */
// Shared constants and types for the FM chip CPU port, write queue and timers
// Import inside module bodies; port headers use scoped names
package opn_pkg;

    // Bus and register widths
    localparam int REG_ADDR_W = 8;
    localparam int DATA_W     = 8;

    // Timer widths as on the chip
    localparam int TA_W        = 10;
    localparam int TB_W        = 8;
    localparam int TB_PRESCALE = 16;                    // Ticks per timer B step
    localparam int TB_PRE_W    = $clog2(TB_PRESCALE);

    // Internal divide-by-6 for the timer tick
    localparam int TICK_DIV   = 6;
    localparam int TICK_CNT_W = $clog2(TICK_DIV);

    // Write queue sizing, depth must be a power of two
    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_CNT_W = QUEUE_PTR_W + 1;

    // Timer register map, part 0 only
    localparam logic [REG_ADDR_W-1:0] REG_TA_HI     = 8'h24; // Timer A bits 9..2
    localparam logic [REG_ADDR_W-1:0] REG_TA_LO     = 8'h25; // Timer A bits 1..0
    localparam logic [REG_ADDR_W-1:0] REG_TB        = 8'h26;
    localparam logic [REG_ADDR_W-1:0] REG_TIMER_CTL = 8'h27;

    // Control register fields
    localparam int CTL_LOAD_A = 0;
    localparam int CTL_LOAD_B = 1;
    localparam int CTL_EN_A   = 2;
    localparam int CTL_EN_B   = 3;
    localparam int CTL_RST_A  = 4;
    localparam int CTL_RST_B  = 5;

    // Status byte on dout
    localparam int STATUS_BUSY   = 7;
    localparam int STATUS_FLAG_B = 1;
    localparam int STATUS_FLAG_A = 0;

    // One register write as stored in the queue
    typedef struct packed {
        logic                  part;
        logic [REG_ADDR_W-1:0] reg_addr;
        logic [DATA_W-1:0]     reg_data;
    } reg_write_t;

endpackage
